/* tb.f */
+incdir+sim
design/simonPkg.sv
design/simonInput.sv
design/simonKeySchedule.sv
design/simonCore.sv
design/simonOutput.sv
design/simonTop.sv
sim/simonTb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module simonTb -o simonSim

run: compile
	./obj_dir/simonSim | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/simonModel.svh */
`ifndef SIMON_MODEL_SVH
`define SIMON_MODEL_SVH

// Bit i of z0 in published order feeds expanded key i+4
localparam logic [0:61] z0Ref =
	62'b11111010001001010110000111001101111101000100101011000011100110;

function automatic logic [15:0] rotLeft(input logic [15:0] x, input int n);
	return (x << n) | (x >> (16 - n));
endfunction

function automatic logic [15:0] rotRight(input logic [15:0] x, input int n);
	return (x >> n) | (x << (16 - n));
endfunction

function automatic logic [15:0] mixF(input logic [15:0] x);
	return (rotLeft(x, 1) & rotLeft(x, 8)) ^ rotLeft(x, 2);
endfunction

// Key word 0 sits in bits 15:0
function automatic logic [15:0] scheduleWord(input logic [63:0] keyBits, input int idx);
	logic [15:0] ks [0:31];
	logic [15:0] tmp;
	for (int i = 0; i < 4; i++)
	begin
		ks[i] = keyBits[16*i +: 16];
	end
	for (int i = 4; i < 32; i++)
	begin
		tmp = rotRight(ks[i-1], 3) ^ ks[i-3];
		tmp = tmp ^ rotRight(tmp, 1);
		ks[i] = ~ks[i-4] ^ tmp ^ {15'b0, z0Ref[i-4]} ^ 16'h0003;
	end
	return ks[idx];
endfunction

function automatic logic [31:0] encryptBlock(input logic [63:0] keyBits, input logic [31:0] pt);
	logic [15:0] x;
	logic [15:0] y;
	logic [15:0] t;
	x = pt[31:16];
	y = pt[15:0];
	for (int i = 0; i < 32; i++)
	begin
		t = x;
		x = y ^ mixF(x) ^ scheduleWord(keyBits, i);
		y = t;
	end
	return {x, y};
endfunction

// Inverse round applied from the last key down
function automatic logic [31:0] decryptBlock(input logic [63:0] keyBits, input logic [31:0] ct);
	logic [15:0] x;
	logic [15:0] y;
	logic [15:0] t;
	x = ct[31:16];
	y = ct[15:0];
	for (int i = 31; i >= 0; i--)
	begin
		t = y;
		y = x ^ mixF(y) ^ scheduleWord(keyBits, i);
		x = t;
	end
	return {x, y};
endfunction

`endif

/* sim/simonTb.sv */
module simonTb
	import simonPkg::*;
();

	localparam int numBlocks = 50;
	localparam int numKeys = 4;
	localparam int cycleLimit = numBlocks * 70 + numKeys * 40 + 200;

	logic clk;
	logic nR;
	logic newData;
	logic newKey;
	logic readData;
	simonBlock inData;
	simonInfo infoIn;
	logic [7:0] countIn;
	simonKey key;
	simonBlock outData;
	simonInfo infoOut;
	logic [7:0] countOut;
	logic doneData;
	logic keyReady;

	int seed = 32'hc51f;
	int errorCount = 0;
	int testStartErrors = 0;
	int checkCount = 0;
	int blocksSent = 0;
	int cycleCount = 0;
	simonKey curKey;
	simonJob expQ [$];
	logic prevDone = 1'b0;
	simonBlock heldData;
	logic [7:0] tagPatterns [4] = '{8'h00, 8'hff, 8'h5a, 8'ha5};

	`include "simonModel.svh"

	simonTop simonTop_i
	(
		.clk(clk),
		.nR(nR),
		.newData(newData),
		.newKey(newKey),
		.readData(readData),
		.inData(inData),
		.infoIn(infoIn),
		.countIn(countIn),
		.key(key),
		.outData(outData),
		.infoOut(infoOut),
		.countOut(countOut),
		.doneData(doneData),
		.keyReady(keyReady)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#20 clk = ~clk;
		end
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// Compare each new result, then watch it stay put until read
	always @(negedge clk)
	begin : resultCheck
		simonJob expJob;
		if (nR && doneData && !prevDone)
		begin
			if (expQ.size() == 0)
			begin
				$display("a result appeared with no block outstanding");
				errorCount++;
			end
			else
			begin
				expJob = expQ.pop_front();
				checkCount++;
				assert (outData == expJob.block)
				else
				begin
					$display("FAILED outData expected %h got %h", expJob.block, outData);
					errorCount++;
				end
				assert (infoOut == expJob.info)
				else
				begin
					$display("FAILED infoOut expected %h got %h", expJob.info, infoOut);
					errorCount++;
				end
				assert (countOut == expJob.count)
				else
				begin
					$display("FAILED countOut expected %h got %h", expJob.count, countOut);
					errorCount++;
				end
			end
		end
		if (nR && prevDone && !readData)
		begin
			assert (outData == heldData)
			else
			begin
				$display("FAILED outData expected %h got %h", heldData, outData);
				errorCount++;
			end
		end
		prevDone = doneData;
		heldData = outData;
	end

	task automatic checkIdle();
		assert (doneData == 1'b0)
		else
		begin
			$display("FAILED doneData expected 0 got %h", doneData);
			errorCount++;
		end
		assert (keyReady == 1'b0)
		else
		begin
			$display("FAILED keyReady expected 0 got %h", keyReady);
			errorCount++;
		end
		assert (outData == '0)
		else
		begin
			$display("FAILED outData expected 00000000 got %h", outData);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name);
		$display("test %s finished with %0d errors", name, errorCount - testStartErrors);
		testStartErrors = errorCount;
	endtask

	task automatic randomKey(output simonKey k);
		for (int w = 0; w < 4; w++)
		begin
			k[w] = 16'($random(seed));
		end
	endtask

	task automatic loadKey(input simonKey k);
		@(negedge clk);
		key <= k;
		newKey <= 1'b1;
		@(negedge clk);
		newKey <= 1'b0;
		@(negedge clk);
		assert (!keyReady)
		else
		begin
			$display("keyReady did not drop after a new key was loaded");
			errorCount++;
		end
		while (!keyReady)
		begin
			@(negedge clk);
		end
		curKey = k;
	endtask

	function automatic simonBlock cipherFor(input simonKey k, input simonBlock b,
		input simonInfo info);
		if (info.field.encrypt)
		begin
			return encryptBlock(k, b);
		end
		return decryptBlock(k, b);
	endfunction

	// Output info is the input byte with the dir bit flipped
	task automatic sendBlock(input simonBlock b, input simonInfo info, input logic [7:0] cnt,
		input simonBlock expBlock);
		simonJob expJob;
		expJob.block = expBlock;
		expJob.info.raw = info.raw ^ 8'h10;
		expJob.count = cnt;
		@(negedge clk);
		inData <= b;
		infoIn <= info;
		countIn <= cnt;
		newData <= 1'b1;
		expQ.push_back(expJob);
		blocksSent++;
		@(negedge clk);
		newData <= 1'b0;
	endtask

	task automatic collectResult(output simonBlock got);
		while (!doneData)
		begin
			@(negedge clk);
		end
		got = outData;
		readData <= 1'b1;
		@(negedge clk);
		readData <= 1'b0;
	endtask

	task automatic resetState();
		repeat (16)
		begin
			@(negedge clk);
			checkIdle();
		end
		nR <= 1'b1;
		@(negedge clk);
		checkIdle();
		reportTest("resetState");
	endtask

	task automatic knownVector();
		simonKey k;
		simonBlock got;
		simonInfo info;
		k[0] = 16'h0100;
		k[1] = 16'h0908;
		k[2] = 16'h1110;
		k[3] = 16'h1918;
		info.raw = 8'h40;
		assert (encryptBlock(k, 32'h65656877) == 32'hc69be9bb)
		else
		begin
			$display("the reference model does not reproduce the published vector");
			errorCount++;
		end
		loadKey(k);
		sendBlock(32'h65656877, info, 8'h01, 32'hc69be9bb);
		collectResult(got);
		reportTest("knownVector");
	endtask

	task automatic randomBlocks();
		simonKey k;
		simonBlock pt;
		simonBlock got;
		simonInfo info;
		simonInfo back;
		logic [7:0] cnt;
		for (int kn = 0; kn < 2; kn++)
		begin
			randomKey(k);
			loadKey(k);
			for (int n = 0; n < 10; n++)
			begin
				pt = 32'($random(seed));
				info.raw = 8'($random(seed));
				cnt = 8'($random(seed));
				sendBlock(pt, info, cnt, cipherFor(k, pt, info));
				collectResult(got);
				// Opposite direction must give the plaintext back
				back.raw = info.raw ^ 8'h40;
				sendBlock(got, back, cnt + 8'h01, pt);
				collectResult(got);
			end
		end
		reportTest("randomBlocks");
	endtask

	task automatic tagFields();
		simonBlock pt;
		simonBlock got;
		simonInfo info;
		for (int n = 0; n < 4; n++)
		begin
			pt = 32'($random(seed));
			info.raw = tagPatterns[n];
			sendBlock(pt, info, 8'($random(seed)), cipherFor(curKey, pt, info));
			collectResult(got);
		end
		reportTest("tagFields");
	endtask

	task automatic backPressure();
		simonBlock ptA;
		simonBlock ptB;
		simonBlock got;
		simonInfo info;
		ptA = 32'($random(seed));
		ptB = 32'($random(seed));
		info.raw = 8'h41;
		sendBlock(ptA, info, 8'ha0, cipherFor(curKey, ptA, info));
		while (!doneData)
		begin
			@(negedge clk);
		end
		info.raw = 8'h12;
		sendBlock(ptB, info, 8'hb0, cipherFor(curKey, ptB, info));
		// Second block finishes meanwhile and waits in the core
		repeat (100)
		begin
			@(negedge clk);
		end
		assert (doneData)
		else
		begin
			$display("doneData dropped while the first result was still unread");
			errorCount++;
		end
		collectResult(got);
		collectResult(got);
		reportTest("backPressure");
	endtask

	task automatic rekeyBlocks();
		simonKey k;
		simonBlock pt;
		simonBlock got;
		simonInfo info;
		randomKey(k);
		loadKey(k);
		for (int n = 0; n < 3; n++)
		begin
			pt = 32'($random(seed));
			info.raw = 8'($random(seed));
			sendBlock(pt, info, 8'($random(seed)), cipherFor(k, pt, info));
			collectResult(got);
		end
		reportTest("rekeyBlocks");
	endtask

	initial
	begin
		nR = 1'b0;
		newData = 1'b0;
		newKey = 1'b0;
		readData = 1'b0;
		inData = '0;
		infoIn = '0;
		countIn = '0;
		key = '0;
		curKey = '0;
		resetState();
		knownVector();
		randomBlocks();
		tagFields();
		backPressure();
		rekeyBlocks();
		@(negedge clk);
		if (expQ.size() != 0 || checkCount != blocksSent)
		begin
			$display("%0d blocks were sent but %0d results were checked", blocksSent, checkCount);
			errorCount++;
		end
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("TEST RESULT: PASS");
		end
		else
		begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* design/simonTop.sv */
module simonTop
	import simonPkg::*;
(
	input logic clk,
	input logic nR,
	input logic newData,
	input logic newKey,
	input logic readData,
	input simonBlock inData,
	input simonInfo infoIn,
	input logic [7:0] countIn,
	input simonKey key,
	output simonBlock outData,
	output simonInfo infoOut,
	output logic [7:0] countOut,
	output logic doneData,
	output logic keyReady
);

	logic keyLoad;
	simonKey keyWordsIn;
	logic jobPending;
	simonJob job;
	logic jobTake;
	logic [roundIdxBits-1:0] keyIdx;
	simonWord roundKey;
	logic resultValid;
	simonJob resultJob;
	logic outFull;

	simonInput simonInput_i
	(
		.clk(clk),
		.nR(nR),
		.newData(newData),
		.newKey(newKey),
		.inData(inData),
		.infoIn(infoIn),
		.countIn(countIn),
		.key(key),
		.jobTake(jobTake),
		.jobPending(jobPending),
		.job(job),
		.keyLoad(keyLoad),
		.keyWordsIn(keyWordsIn)
	);

	simonKeySchedule simonKeySchedule_i
	(
		.clk(clk),
		.nR(nR),
		.keyLoad(keyLoad),
		.keyWordsIn(keyWordsIn),
		.keyIdx(keyIdx),
		.roundKey(roundKey),
		.keyReady(keyReady)
	);

	simonCore simonCore_i
	(
		.clk(clk),
		.nR(nR),
		.jobPending(jobPending),
		.job(job),
		.keyReady(keyReady),
		.roundKey(roundKey),
		.outFull(outFull),
		.jobTake(jobTake),
		.keyIdx(keyIdx),
		.resultValid(resultValid),
		.resultJob(resultJob)
	);

	simonOutput simonOutput_i
	(
		.clk(clk),
		.nR(nR),
		.resultValid(resultValid),
		.resultJob(resultJob),
		.readData(readData),
		.outData(outData),
		.infoOut(infoOut),
		.countOut(countOut),
		.doneData(doneData),
		.outFull(outFull)
	);

endmodule

/* design/simonOutput.sv */
module simonOutput
	import simonPkg::*;
(
	input logic clk,
	input logic nR,
	input logic resultValid,
	input simonJob resultJob,
	input logic readData,
	output simonBlock outData,
	output simonInfo infoOut,
	output logic [7:0] countOut,
	output logic doneData,
	output logic outFull
);

	simonInfo nextInfo;

	// Same byte with the dir bit flipped
	always_comb
	begin
		nextInfo.raw = resultJob.info.raw;
		nextInfo.field.dir = ~resultJob.info.field.dir;
	end

	always_ff @(posedge clk or negedge nR)
	begin
		if (!nR)
		begin
			outData <= '0;
			infoOut <= '0;
			countOut <= '0;
			doneData <= 1'b0;
		end
		else
		begin
			if (resultValid)
			begin
				outData <= resultJob.block;
				infoOut <= nextInfo;
				countOut <= resultJob.count;
			end
			// New result may land in the same edge as the read
			if (resultValid)
			begin
				doneData <= 1'b1;
			end
			else if (readData && doneData)
			begin
				doneData <= 1'b0;
			end
		end
	end

	assign outFull = doneData;

	assert property (@(posedge clk) disable iff (!nR)
		doneData && !readData |=> $stable(outData))
		else $error("outData changed before it was read");

endmodule

/* design/simonCore.sv */
module simonCore
	import simonPkg::*;
(
	input logic clk,
	input logic nR,
	input logic jobPending,
	input simonJob job,
	input logic keyReady,
	input simonWord roundKey,
	input logic outFull,
	output logic jobTake,
	output logic [roundIdxBits-1:0] keyIdx,
	output logic resultValid,
	output simonJob resultJob
);

	typedef enum logic [1:0] {coreIdle, coreRun, coreHold} coreState;

	coreState state;
	logic [roundIdxBits-1:0] roundCnt;
	simonJob curJob;
	simonBlock loadBlock;
	simonBlock roundOut;
	simonBlock finalBlock;
	logic encrypt;
	logic takeNow;
	logic finishNow;

	function automatic simonWord roundF(simonWord x);
		simonWord r1;
		simonWord r2;
		simonWord r8;
		r1 = {x[wordBits-2:0], x[wordBits-1]};
		r2 = {x[wordBits-3:0], x[wordBits-1:wordBits-2]};
		r8 = {x[wordBits-9:0], x[wordBits-1:wordBits-8]};
		return (r1 & r8) ^ r2;
	endfunction

	assign encrypt = curJob.info.field.encrypt;
	assign takeNow = (state == coreIdle) && jobPending && keyReady;
	assign finishNow = (state == coreHold) && !outFull;

	// Decrypt walks the key table backwards
	assign keyIdx = encrypt ? roundCnt : roundIdxBits'(rounds - 1) - roundCnt;

	always_comb
	begin
		if (job.info.field.encrypt)
		begin
			loadBlock = job.block;
		end
		else
		begin
			loadBlock.hi = job.block.lo;
			loadBlock.lo = job.block.hi;
		end
		roundOut.hi = curJob.block.lo ^ roundF(curJob.block.hi) ^ roundKey;
		roundOut.lo = curJob.block.hi;
		if (encrypt)
		begin
			finalBlock = curJob.block;
		end
		else
		begin
			finalBlock.hi = curJob.block.lo;
			finalBlock.lo = curJob.block.hi;
		end
	end

	always_ff @(posedge clk or negedge nR)
	begin
		if (!nR)
		begin
			state <= coreIdle;
			roundCnt <= '0;
			jobTake <= 1'b0;
			resultValid <= 1'b0;
		end
		else
		begin
			jobTake <= takeNow;
			resultValid <= finishNow;
			case (state)
				coreIdle:
				begin
					if (takeNow)
					begin
						roundCnt <= '0;
						state <= coreRun;
					end
				end
				coreRun:
				begin
					roundCnt <= roundCnt + roundIdxBits'(1);
					if (roundCnt == roundIdxBits'(rounds - 1))
					begin
						state <= coreHold;
					end
				end
				coreHold:
				begin
					// Wait here while the output is still full
					if (finishNow)
					begin
						state <= coreIdle;
					end
				end
				default:
				begin
					state <= coreIdle;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (takeNow)
		begin
			curJob.block <= loadBlock;
			curJob.info <= job.info;
			curJob.count <= job.count;
		end
		else if (state == coreRun)
		begin
			curJob.block <= roundOut;
		end
		if (finishNow)
		begin
			resultJob.block <= finalBlock;
			resultJob.info <= curJob.info;
			resultJob.count <= curJob.count;
		end
	end

	assert property (@(posedge clk) disable iff (!nR)
		resultValid |-> !outFull)
		else $error("result sent into a full output");

	assert property (@(posedge clk) disable iff (!nR)
		jobTake |-> keyReady)
		else $error("job taken while keys not ready");

endmodule

/* design/simonKeySchedule.sv */
module simonKeySchedule
	import simonPkg::*;
(
	input logic clk,
	input logic nR,
	input logic keyLoad,
	input simonKey keyWordsIn,
	input logic [roundIdxBits-1:0] keyIdx,
	output simonWord roundKey,
	output logic keyReady
);

	simonWord keyTable [rounds];
	logic [roundIdxBits-1:0] expCnt;
	logic [roundIdxBits-1:0] idx1;
	logic [roundIdxBits-1:0] idx3;
	logic [roundIdxBits-1:0] idx4;
	logic expanding;
	logic zBit;
	simonWord tmpRot;
	simonWord tmpMix;
	simonWord nextKey;

	assign idx1 = expCnt + roundIdxBits'(1);
	assign idx3 = expCnt + roundIdxBits'(3);
	assign idx4 = expCnt + roundIdxBits'(keyWords);
	assign zBit = zSeq[$bits(zSeq) - 1 - int'(expCnt)];

	// k[i+4] = c ^ z[i] ^ k[i] ^ (I ^ S^-1)(S^-3 k[i+3] ^ k[i+1])
	always_comb
	begin
		tmpRot = {keyTable[idx3][2:0], keyTable[idx3][wordBits-1:3]};
		tmpMix = tmpRot ^ keyTable[idx1];
		nextKey = keyTable[expCnt] ^ tmpMix ^ {tmpMix[0], tmpMix[wordBits-1:1]}
			^ keyConst ^ simonWord'(zBit);
	end

	always_ff @(posedge clk or negedge nR)
	begin
		if (!nR)
		begin
			for (int i = 0; i < rounds; i++)
			begin
				keyTable[i] <= '0;
			end
			expCnt <= '0;
			expanding <= 1'b0;
			keyReady <= 1'b0;
		end
		else if (keyLoad)
		begin
			for (int i = 0; i < keyWords; i++)
			begin
				keyTable[i] <= keyWordsIn[i];
			end
			expCnt <= '0;
			expanding <= 1'b1;
			keyReady <= 1'b0;
		end
		else if (expanding)
		begin
			keyTable[idx4] <= nextKey;
			expCnt <= expCnt + roundIdxBits'(1);
			if (expCnt == roundIdxBits'(rounds - keyWords - 1))
			begin
				expanding <= 1'b0;
				keyReady <= 1'b1;
			end
		end
	end

	// Combinational table read for the core
	assign roundKey = keyTable[keyIdx];

	assert property (@(posedge clk) disable iff (!nR)
		keyLoad |=> !keyReady [*28] ##1 keyReady)
		else $error("key expansion length wrong");

endmodule

/* design/simonInput.sv */
module simonInput
	import simonPkg::*;
(
	input logic clk,
	input logic nR,
	input logic newData,
	input logic newKey,
	input simonBlock inData,
	input simonInfo infoIn,
	input logic [7:0] countIn,
	input simonKey key,
	input logic jobTake,
	output logic jobPending,
	output simonJob job,
	output logic keyLoad,
	output simonKey keyWordsIn
);

	logic prevData;
	logic prevKey;
	logic dataRise;
	logic keyRise;

	// Strobe seen low on the previous edge and high now
	assign dataRise = newData && !prevData;
	assign keyRise = newKey && !prevKey;

	always_ff @(posedge clk or negedge nR)
	begin
		if (!nR)
		begin
			prevData <= 1'b0;
			prevKey <= 1'b0;
			jobPending <= 1'b0;
			keyLoad <= 1'b0;
		end
		else
		begin
			prevData <= newData;
			prevKey <= newKey;
			keyLoad <= keyRise;
			// A fresh block beats the take of the old one
			if (dataRise)
			begin
				jobPending <= 1'b1;
			end
			else if (jobTake)
			begin
				jobPending <= 1'b0;
			end
		end
	end

	// Pending block is simply overwritten by a newer one
	always_ff @(posedge clk)
	begin
		if (dataRise)
		begin
			job.block <= inData;
			job.info <= infoIn;
			job.count <= countIn;
		end
		if (keyRise)
		begin
			keyWordsIn <= key;
		end
	end

	assert property (@(posedge clk) disable iff (!nR)
		jobTake |-> jobPending)
		else $error("jobTake without a pending job");

endmodule

/* design/simonPkg.sv */
package simonPkg;

	// SIMON 32/64 geometry
	localparam int wordBits = 16;
	localparam int keyWords = 4;
	localparam int rounds = 32;
	localparam int roundIdxBits = 5;

	// z0 sequence with its first bit in the MSB
	localparam logic [61:0] zSeq =
		62'b11111010_00100101_01100001_11001101_11110100_01001010_11000011_100110;

	// Round constant c = 2^n - 4
	localparam logic [wordBits-1:0] keyConst = 16'hfffc;

	typedef logic [wordBits-1:0] simonWord;

	typedef struct packed
	{
		simonWord hi;
		simonWord lo;
	} simonBlock;

	// Word 0 is the first round key
	typedef simonWord [keyWords-1:0] simonKey;

	// Info byte seen raw or by field
	typedef union packed
	{
		logic [7:0] raw;
		struct packed
		{
			logic spare;
			logic encrypt;
			logic tag;
			logic dir;
			logic [3:0] channel;
		} field;
	} simonInfo;

	typedef struct packed
	{
		simonBlock block;
		simonInfo info;
		logic [7:0] count;
	} simonJob;

endpackage
